// File: project.f
hdl/rx_pkg.sv
hdl/gmii_rx_align.sv
hdl/crc32_rx.sv
hdl/frame_writer.sv
hdl/frame_buffer.sv
hdl/frame_reader.sv
hdl/gmii_rx_top.sv
sim/tb_gmii_rx.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the GMII receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_gmii_rx -f project.f
sim_out=$(./obj_dir/Vtb_gmii_rx)
echo "$sim_out"
if echo "$sim_out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

// File: sim/tb_gmii_rx.sv
`timescale 1ns/1ps

module tb_gmii_rx;

  localparam logic [31:0]   SEED          = 32'h7162_b0f6;
  localparam int            CREDIT_START  = 4;
  localparam int            MIN_LEN       = 64;
  localparam int            MAX_LEN       = 1518;
  localparam rx_pkg::byte_t TTE_TYPE      = 8'h92;
  localparam rx_pkg::byte_t IP_TYPE       = 8'h08;

  typedef rx_pkg::byte_t byte_q_t [$];

  logic          rx_clk = 1'b0;
  logic          rstn;
  logic          rx_dv;
  rx_pkg::byte_t rx_d;
  logic          credit_return = 1'b0;
  logic          out_valid;
  rx_pkg::byte_t out_data;
  logic          out_last;
  logic          out_tte;
  logic          out_crc_err;
  logic          out_len_err;
  logic          frame_drop;

  byte_q_t       exp_data;
  logic          exp_last [$];
  logic [2:0]    exp_flags [$];   // {tte, crc_err, len_err}
  int            due_q [$];       // cycle at which each credit goes back
  logic [31:0]   stim_seed = SEED;
  logic [31:0]   credit_seed = ~SEED;
  logic          hold = 1'b0;     // credits withheld
  int            cycles = 0;
  int            bytes_sent = 0;
  int            sent = 0;
  int            returned = 0;
  int            drops = 0;
  int            data_errors = 0;
  int            flag_errors = 0;
  int            protocol_errors = 0;

  gmii_rx_top dut (
    .rx_clk        (rx_clk),
    .rstn          (rstn),
    .rx_dv         (rx_dv),
    .rx_d          (rx_d),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_last      (out_last),
    .out_tte       (out_tte),
    .out_crc_err   (out_crc_err),
    .out_len_err   (out_len_err),
    .frame_drop    (frame_drop)
  );

  always #20 rx_clk = ~rx_clk;

  // =====================================================================
  // reference model
  // =====================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reflected 802.3 CRC sent low byte first
  function automatic logic [31:0] eth_fcs(input byte_q_t d);
    logic [31:0] c;
    c = 32'hffff_ffff;
    foreach (d[i]) begin
      c = c ^ {24'h0, d[i]};
      for (int b = 0; b < 8; b++) c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
    end
    return ~c;
  endfunction

  function automatic logic [2:0] ref_flags(input byte_q_t f, input bit corrupt);
    logic tte;
    logic len_err;
    tte     = (f.size() > 12) && (f[12] == TTE_TYPE);
    len_err = (f.size() < MIN_LEN) || (f.size() > MAX_LEN);
    return {tte, corrupt, len_err};
  endfunction

  // =====================================================================
  // stimulus
  // =====================================================================
  task automatic put_byte(input logic dv, input rx_pkg::byte_t d);
    @(negedge rx_clk);
    rx_dv <= dv;
    rx_d  <= d;
    if (dv) bytes_sent = bytes_sent + 1;
  endtask

  // total counts the bytes after the SFD including the FCS
  task automatic send_frame(input int total, input rx_pkg::byte_t type_hi,
                            input bit corrupt, input bit dropped);
    byte_q_t     f;
    logic [31:0] fcs;
    @(posedge rx_clk);
    for (int i = 0; i < total - 4; i++) begin
      stim_seed = xorshift32(stim_seed);
      f.push_back(stim_seed[7:0]);
    end
    f[12] = type_hi;
    fcs   = eth_fcs(f);
    if (corrupt) begin
      stim_seed = xorshift32(stim_seed);
      fcs       = fcs ^ (32'h1 << stim_seed[4:0]);   // one bit flipped
    end
    for (int k = 0; k < 4; k++) f.push_back(fcs[8*k +: 8]);
    if (!dropped) begin
      foreach (f[i]) begin
        exp_data.push_back(f[i]);
        exp_last.push_back(i == f.size() - 1);
      end
      exp_flags.push_back(ref_flags(f, corrupt));
    end
    repeat (7) put_byte(1'b1, 8'h55);
    put_byte(1'b1, 8'hd5);
    foreach (f[i]) put_byte(1'b1, f[i]);
    repeat (12) put_byte(1'b0, 8'h00);   // inter-frame gap
  endtask

  task automatic send_false_start();
    repeat (7) put_byte(1'b1, 8'h55);    // preamble without SFD
    repeat (12) put_byte(1'b0, 8'h00);
  endtask

  task automatic wait_drain();
    do @(posedge rx_clk); while (exp_data.size() != 0 || due_q.size() != 0);
    repeat (4) @(posedge rx_clk);       // let the slot release settle
  endtask

  task automatic report_counts();
    $display("errors: data %0d, flags %0d, protocol %0d",
             data_errors, flag_errors, protocol_errors);
  endtask

  // =====================================================================
  // monitors
  // =====================================================================
  always @(posedge rx_clk) begin
    cycles = cycles + 1;
    if (credit_return) returned = returned + 1;
    if (cycles > 20 * bytes_sent + 2000) begin
      $display("timeout: output stream stalled after %0d cycles", cycles);
      report_counts();
      $display("Finished with errors");
      $finish;
    end
  end

  always @(negedge rx_clk) begin : check_output
    rx_pkg::byte_t e_byte;
    logic          e_last;
    logic [2:0]    e_flags;
    if (rstn && frame_drop) drops = drops + 1;
    if (rstn && out_valid) begin
      sent = sent + 1;
      assert (sent <= CREDIT_START + returned) else begin
        $display("credit rule broken: %0d bytes sent with %0d credits returned",
                 sent, returned);
        protocol_errors++;
      end
      assert (exp_data.size() != 0) else begin
        $display("output byte %h arrived with no frame expected", out_data);
        protocol_errors++;
      end
      if (exp_data.size() != 0) begin
        e_byte = exp_data.pop_front();
        e_last = exp_last.pop_front();
        assert (out_data == e_byte) else begin
          $display("Fail out_data: got %h expected %h", out_data, e_byte);
          data_errors++;
        end
        assert (out_last == e_last) else begin
          $display("Fail out_last: got %h expected %h", out_last, e_last);
          data_errors++;
        end
        if (e_last) begin
          e_flags = exp_flags.pop_front();
          assert (out_tte == e_flags[2]) else begin
            $display("Fail out_tte: got %h expected %h", out_tte, e_flags[2]);
            flag_errors++;
          end
          assert (out_crc_err == e_flags[1]) else begin
            $display("Fail out_crc_err: got %h expected %h", out_crc_err, e_flags[1]);
            flag_errors++;
          end
          assert (out_len_err == e_flags[0]) else begin
            $display("Fail out_len_err: got %h expected %h", out_len_err, e_flags[0]);
            flag_errors++;
          end
        end
      end
    end
  end

  // one credit per byte back after 0 to 7 cycles
  always @(negedge rx_clk) begin : credit_gen
    if (!rstn) begin
      credit_return <= 1'b0;
    end else begin
      if (out_valid) begin
        credit_seed = xorshift32(credit_seed);
        due_q.push_back(cycles + int'(credit_seed[2:0]));
      end
      if (!hold && due_q.size() != 0 && due_q[0] <= cycles) begin
        credit_return <= 1'b1;
        void'(due_q.pop_front());
      end else begin
        credit_return <= 1'b0;
      end
    end
  end

  // =====================================================================
  // test sequence
  // =====================================================================
  initial begin
    rstn  = 1'b0;
    rx_dv = 1'b0;
    rx_d  = 8'h00;
    repeat (3) @(negedge rx_clk);
    rstn <= 1'b1;

    send_frame(64, IP_TYPE, 1'b0, 1'b0);          // plain best-effort
    wait_drain();
    send_frame(72, TTE_TYPE, 1'b0, 1'b0);
    send_frame(72, IP_TYPE, 1'b0, 1'b0);
    wait_drain();
    send_frame(80, IP_TYPE, 1'b1, 1'b0);          // bad FCS
    send_frame(40, IP_TYPE, 1'b0, 1'b0);          // runt
    wait_drain();
    send_frame(1530, IP_TYPE, 1'b0, 1'b0);        // oversize
    wait_drain();
    stim_seed = xorshift32(stim_seed);
    send_frame(64 + int'(stim_seed[6:0]), IP_TYPE, 1'b0, 1'b0);
    stim_seed = xorshift32(stim_seed);
    send_frame(64 + int'(stim_seed[6:0]), TTE_TYPE, 1'b0, 1'b0);
    wait_drain();
    send_false_start();
    send_frame(68, IP_TYPE, 1'b0, 1'b0);
    wait_drain();
    assert (drops == 0) else begin
      $display("Fail frame_drop count: got %h expected %h", drops, 0);
      protocol_errors++;
    end

    // both slots held so the third frame has nowhere to go
    hold = 1'b1;
    send_frame(70, IP_TYPE, 1'b0, 1'b0);
    send_frame(80, TTE_TYPE, 1'b0, 1'b0);
    send_frame(66, IP_TYPE, 1'b0, 1'b1);
    repeat (4) @(posedge rx_clk);
    assert (drops == 1) else begin
      $display("Fail frame_drop count: got %h expected %h", drops, 1);
      protocol_errors++;
    end
    hold = 1'b0;
    wait_drain();
    repeat (20) @(posedge rx_clk);
    assert (drops == 1) else begin
      $display("Fail frame_drop count: got %h expected %h", drops, 1);
      protocol_errors++;
    end

    report_counts();
    if (data_errors + flag_errors + protocol_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: hdl/gmii_rx_top.sv
`timescale 1ns/1ps

module gmii_rx_top (
  input  logic          rx_clk,
  input  logic          rstn,
  input  logic          rx_dv,
  input  rx_pkg::byte_t rx_d,
  input  logic          credit_return,
  output logic          out_valid,
  output rx_pkg::byte_t out_data,
  output logic          out_last,
  output logic          out_tte,
  output logic          out_crc_err,
  output logic          out_len_err,
  output logic          frame_drop
);

  // aligner to writer
  logic               fb_valid;
  logic               fb_start;
  logic               fb_end;
  rx_pkg::byte_t      fb_data;
  // buffer ports
  logic               wr_en;
  rx_pkg::buf_addr_t  wr_addr;
  rx_pkg::byte_t      wr_data;
  logic               rd_en;
  rx_pkg::buf_addr_t  rd_addr;
  rx_pkg::byte_t      rd_data;
  // writer to reader
  logic               desc_valid;
  rx_pkg::slot_t      desc_slot;
  rx_pkg::frame_len_t desc_len;
  logic               desc_tte;
  logic               desc_crc_err;
  logic               desc_len_err;
  logic               slot_release;
  rx_pkg::slot_t      release_slot;

  gmii_rx_align u_align (
    .rx_clk (rx_clk), .rstn (rstn), .rx_dv (rx_dv), .rx_d (rx_d),
    .fb_valid (fb_valid), .fb_start (fb_start), .fb_end (fb_end), .fb_data (fb_data)
  );

  frame_writer u_writer (
    .rx_clk (rx_clk), .rstn (rstn),
    .fb_valid (fb_valid), .fb_start (fb_start), .fb_end (fb_end), .fb_data (fb_data),
    .slot_release (slot_release), .release_slot (release_slot),
    .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data),
    .desc_valid (desc_valid), .desc_slot (desc_slot), .desc_len (desc_len),
    .desc_tte (desc_tte), .desc_crc_err (desc_crc_err), .desc_len_err (desc_len_err),
    .frame_drop (frame_drop)
  );

  frame_buffer u_buffer (
    .rx_clk (rx_clk), .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data),
    .rd_en (rd_en), .rd_addr (rd_addr), .rd_data (rd_data)
  );

  frame_reader u_reader (
    .rx_clk (rx_clk), .rstn (rstn),
    .desc_valid (desc_valid), .desc_slot (desc_slot), .desc_len (desc_len),
    .desc_tte (desc_tte), .desc_crc_err (desc_crc_err), .desc_len_err (desc_len_err),
    .credit_return (credit_return), .rd_data (rd_data),
    .rd_en (rd_en), .rd_addr (rd_addr),
    .slot_release (slot_release), .release_slot (release_slot),
    .out_valid (out_valid), .out_data (out_data), .out_last (out_last),
    .out_tte (out_tte), .out_crc_err (out_crc_err), .out_len_err (out_len_err)
  );

endmodule

// File: hdl/frame_reader.sv
`timescale 1ns/1ps

module frame_reader (
  input  logic               rx_clk,
  input  logic               rstn,
  input  logic               desc_valid,
  input  rx_pkg::slot_t      desc_slot,
  input  rx_pkg::frame_len_t desc_len,
  input  logic               desc_tte,
  input  logic               desc_crc_err,
  input  logic               desc_len_err,
  input  logic               credit_return,
  input  rx_pkg::byte_t      rd_data,
  output logic               rd_en,
  output rx_pkg::buf_addr_t  rd_addr,
  output logic               slot_release,
  output rx_pkg::slot_t      release_slot,
  output logic               out_valid,
  output rx_pkg::byte_t      out_data,
  output logic               out_last,
  output logic               out_tte,
  output logic               out_crc_err,
  output logic               out_len_err
);

  localparam int QD = rx_pkg::NUM_SLOTS;   // one entry per slot is enough

  rx_pkg::slot_t         q_slot    [QD];
  rx_pkg::frame_len_t    q_len     [QD];
  logic                  q_tte     [QD];
  logic                  q_crc_err [QD];
  logic                  q_len_err [QD];
  logic                  q_wp;
  logic                  q_rp;
  logic [1:0]            q_cnt;
  rx_pkg::reader_state_t state;
  rx_pkg::credit_t       credits;
  rx_pkg::slot_t         cur_slot;
  rx_pkg::frame_len_t    rd_idx;
  rx_pkg::frame_len_t    last_idx;
  logic                  cur_tte;
  logic                  cur_crc_err;
  logic                  cur_len_err;
  logic                  pop;
  logic                  send;
  logic                  is_last;

  assign pop      = (state == rx_pkg::RD_IDLE) && (q_cnt != 2'd0);
  assign send     = (state == rx_pkg::RD_STREAM) && (credits != '0);
  assign is_last  = (rd_idx == last_idx);
  assign rd_en    = send;                    // one credit buys one RAM read
  assign rd_addr  = {cur_slot, rd_idx};
  assign out_data = rd_data;

  always_ff @(posedge rx_clk) begin
    if (desc_valid) begin
      q_slot[q_wp]    <= desc_slot;
      q_len[q_wp]     <= desc_len;
      q_tte[q_wp]     <= desc_tte;
      q_crc_err[q_wp] <= desc_crc_err;
      q_len_err[q_wp] <= desc_len_err;
    end
  end

  // =====================================================================
  // queue pointers and credit count
  // =====================================================================
  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      q_wp    <= 1'b0;
      q_rp    <= 1'b0;
      q_cnt   <= 2'd0;
      credits <= rx_pkg::credit_t'(rx_pkg::CREDIT_INIT);
    end else begin
      if (desc_valid) q_wp <= ~q_wp;
      if (pop) q_rp <= ~q_rp;
      case ({desc_valid, pop})
        2'b10:   q_cnt <= q_cnt + 2'd1;
        2'b01:   q_cnt <= q_cnt - 2'd1;
        default: q_cnt <= q_cnt;
      endcase
      case ({credit_return, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // =====================================================================
  // read-out FSM
  // =====================================================================
  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      state        <= rx_pkg::RD_IDLE;
      cur_slot     <= 1'b0;
      rd_idx       <= '0;
      last_idx     <= '0;
      cur_tte      <= 1'b0;
      cur_crc_err  <= 1'b0;
      cur_len_err  <= 1'b0;
      out_valid    <= 1'b0;
      out_last     <= 1'b0;
      out_tte      <= 1'b0;
      out_crc_err  <= 1'b0;
      out_len_err  <= 1'b0;
      slot_release <= 1'b0;
      release_slot <= 1'b0;
    end else begin
      out_valid    <= 1'b0;
      out_last     <= 1'b0;
      out_tte      <= 1'b0;
      out_crc_err  <= 1'b0;
      out_len_err  <= 1'b0;
      slot_release <= 1'b0;
      case (state)
        rx_pkg::RD_IDLE: begin
          if (pop) begin
            cur_slot    <= q_slot[q_rp];
            cur_tte     <= q_tte[q_rp];
            cur_crc_err <= q_crc_err[q_rp];
            cur_len_err <= q_len_err[q_rp];
            rd_idx      <= '0;
            last_idx    <= q_len[q_rp] - 1'b1;   // writer caps length inside the slot
            state       <= rx_pkg::RD_STREAM;
          end
        end
        rx_pkg::RD_STREAM: begin
          if (send) begin
            out_valid   <= 1'b1;             // data arrives with the RAM read
            out_last    <= is_last;
            out_tte     <= is_last & cur_tte;
            out_crc_err <= is_last & cur_crc_err;
            out_len_err <= is_last & cur_len_err;
            rd_idx      <= rd_idx + 1'b1;
            if (is_last) state <= rx_pkg::RD_DONE;
          end
        end
        rx_pkg::RD_DONE: begin
          slot_release <= 1'b1;              // cycle after the last byte
          release_slot <= cur_slot;
          state        <= rx_pkg::RD_IDLE;
        end
        default: state <= rx_pkg::RD_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
  input  logic              rx_clk,
  input  logic              wr_en,
  input  rx_pkg::buf_addr_t wr_addr,
  input  rx_pkg::byte_t     wr_data,
  input  logic              rd_en,
  input  rx_pkg::buf_addr_t rd_addr,
  output rx_pkg::byte_t     rd_data
);

  localparam int DEPTH = rx_pkg::NUM_SLOTS * rx_pkg::SLOT_BYTES;

  rx_pkg::byte_t mem [DEPTH];   // slot number is the address msb

  always_ff @(posedge rx_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, holds its value while rd_en is low
  always_ff @(posedge rx_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: hdl/frame_writer.sv
`timescale 1ns/1ps

module frame_writer (
  input  logic               rx_clk,
  input  logic               rstn,
  input  logic               fb_valid,
  input  logic               fb_start,
  input  logic               fb_end,
  input  rx_pkg::byte_t      fb_data,
  input  logic               slot_release,
  input  rx_pkg::slot_t      release_slot,
  output logic               wr_en,
  output rx_pkg::buf_addr_t  wr_addr,
  output rx_pkg::byte_t      wr_data,
  output logic               desc_valid,
  output rx_pkg::slot_t      desc_slot,
  output rx_pkg::frame_len_t desc_len,
  output logic               desc_tte,
  output logic               desc_crc_err,
  output logic               desc_len_err,
  output logic               frame_drop
);

  rx_pkg::writer_state_t        state;
  logic [rx_pkg::NUM_SLOTS-1:0] busy;
  logic [rx_pkg::NUM_SLOTS-1:0] busy_next;
  rx_pkg::slot_t                cur_slot;
  rx_pkg::slot_t                free_slot;
  rx_pkg::slot_t                slot_sel;
  rx_pkg::frame_len_t           wr_idx;          // index of the next byte
  rx_pkg::frame_len_t           idx_sel;
  rx_pkg::frame_len_t           frame_len;
  logic                         idx_full;        // slot index space used up
  logic                         tte_seen;
  logic                         start_byte;
  logic                         slot_free;
  logic                         crc_ok;

  assign start_byte = fb_valid & fb_start;
  assign slot_free  = ~&busy;
  assign free_slot  = rx_pkg::slot_t'(busy[0]);  // lowest free slot
  assign slot_sel   = start_byte ? free_slot : cur_slot;
  assign idx_sel    = start_byte ? rx_pkg::frame_len_t'(0) : wr_idx;
  assign frame_len  = wr_idx;                    // stops at 2047 on an oversized frame
  assign frame_drop = (state == rx_pkg::WR_DROP) & fb_end;

  crc32_rx u_crc (
    .rx_clk   (rx_clk),
    .rstn     (rstn),
    .crc_init (start_byte),
    .crc_step (fb_valid),
    .crc_data (fb_data),
    .crc_ok   (crc_ok)
  );

  always_comb begin
    busy_next = busy;
    if (slot_release) busy_next[release_slot] = 1'b0;
    if (state == rx_pkg::WR_IDLE && start_byte && slot_free) busy_next[free_slot] = 1'b1;
  end

  always_ff @(posedge rx_clk) begin
    wr_data <= fb_data;
    wr_addr <= {slot_sel, idx_sel};
    if (state == rx_pkg::WR_WRITE && fb_end) begin
      desc_slot    <= cur_slot;
      desc_len     <= frame_len;
      desc_tte     <= tte_seen;
      desc_crc_err <= ~crc_ok;                   // last step was the cycle before
      desc_len_err <= (frame_len < rx_pkg::MIN_FRAME_LEN) ||
                      (frame_len > rx_pkg::MAX_FRAME_LEN);
    end
  end

  // =====================================================================
  // slot allocation and write FSM
  // =====================================================================
  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      state      <= rx_pkg::WR_IDLE;
      busy       <= '0;
      cur_slot   <= 1'b0;
      wr_idx     <= '0;
      idx_full   <= 1'b0;
      tte_seen   <= 1'b0;
      wr_en      <= 1'b0;
      desc_valid <= 1'b0;
    end else begin
      busy       <= busy_next;
      wr_en      <= 1'b0;
      desc_valid <= 1'b0;
      case (state)
        rx_pkg::WR_IDLE: begin
          if (start_byte) begin
            tte_seen <= 1'b0;
            idx_full <= 1'b0;
            if (slot_free) begin
              cur_slot <= free_slot;
              wr_en    <= 1'b1;
              wr_idx   <= 11'd1;
              state    <= rx_pkg::WR_WRITE;
            end else begin
              state <= rx_pkg::WR_DROP;          // both slots still draining
            end
          end
        end
        rx_pkg::WR_WRITE: begin
          if (fb_valid && !idx_full) begin
            wr_en <= 1'b1;
            if (wr_idx == '1) idx_full <= 1'b1;
            else wr_idx <= wr_idx + 1'b1;
            if (wr_idx == rx_pkg::TTE_MARK_INDEX && fb_data == rx_pkg::TTE_MARK) begin
              tte_seen <= 1'b1;
            end
          end
          if (fb_end) state <= rx_pkg::WR_POST;
        end
        rx_pkg::WR_DROP: begin
          if (fb_end) state <= rx_pkg::WR_IDLE;
        end
        rx_pkg::WR_POST: begin
          desc_valid <= 1'b1;
          state      <= rx_pkg::WR_IDLE;
        end
        default: state <= rx_pkg::WR_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/crc32_rx.sv
`timescale 1ns/1ps

module crc32_rx (
  input  logic          rx_clk,
  input  logic          rstn,
  input  logic          crc_init,
  input  logic          crc_step,
  input  rx_pkg::byte_t crc_data,
  output logic          crc_ok
);

  rx_pkg::crc_t crc_q;
  rx_pkg::crc_t crc_base;

  // one byte through the 802.3 polynomial with bit 0 of the byte first
  function automatic rx_pkg::crc_t crc_fold(input rx_pkg::crc_t c, input rx_pkg::byte_t d);
    rx_pkg::crc_t r;
    logic         fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[31] ^ d[i];
      r  = {r[30:0], 1'b0} ^ (fb ? 32'h04c1_1db7 : 32'h0);
    end
    return r;
  endfunction

  assign crc_base = crc_init ? '1 : crc_q;  // init and first byte share a cycle

  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      crc_q <= '1;
    end else if (crc_step) begin
      crc_q <= crc_fold(crc_base, crc_data);
    end
  end

  assign crc_ok = (crc_q == rx_pkg::CRC_RESIDUE);

endmodule

// File: hdl/gmii_rx_align.sv
`timescale 1ns/1ps

module gmii_rx_align (
  input  logic          rx_clk,
  input  logic          rstn,
  input  logic          rx_dv,
  input  rx_pkg::byte_t rx_d,
  output logic          fb_valid,
  output logic          fb_start,
  output logic          fb_end,
  output rx_pkg::byte_t fb_data
);

  logic                 dv_r;
  logic                 dv_r2;
  rx_pkg::byte_t        d_r;
  logic                 dv_rise;
  logic                 dv_fall;
  logic                 first_pend;        // next data byte opens the frame
  rx_pkg::align_state_t state;

  assign dv_rise = dv_r & ~dv_r2;
  assign dv_fall = ~dv_r & dv_r2;

  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      dv_r  <= 1'b0;
      dv_r2 <= 1'b0;
    end else begin
      dv_r  <= rx_dv;
      dv_r2 <= dv_r;
    end
  end

  always_ff @(posedge rx_clk) begin
    d_r     <= rx_d;
    fb_data <= d_r;                       // lines up with fb_valid
  end

  // =====================================================================
  // preamble hunt
  // =====================================================================
  always_ff @(posedge rx_clk or negedge rstn) begin
    if (!rstn) begin
      state      <= rx_pkg::ALIGN_IDLE;
      fb_valid   <= 1'b0;
      fb_start   <= 1'b0;
      fb_end     <= 1'b0;
      first_pend <= 1'b0;
    end else begin
      fb_valid <= 1'b0;
      fb_start <= 1'b0;
      fb_end   <= 1'b0;
      case (state)
        rx_pkg::ALIGN_IDLE: begin
          if (dv_rise) begin
            if (d_r == rx_pkg::SFD_BYTE) begin
              state      <= rx_pkg::ALIGN_DATA;   // short preamble, SFD first
              first_pend <= 1'b1;
            end else if (d_r == rx_pkg::PREAMBLE_BYTE) begin
              state <= rx_pkg::ALIGN_HUNT;
            end else begin
              state <= rx_pkg::ALIGN_WAIT_IDLE;
            end
          end
        end
        rx_pkg::ALIGN_HUNT: begin
          if (!dv_r) begin
            state <= rx_pkg::ALIGN_IDLE;         // no SFD seen, nothing sent
          end else if (d_r == rx_pkg::SFD_BYTE) begin
            state      <= rx_pkg::ALIGN_DATA;
            first_pend <= 1'b1;
          end else if (d_r != rx_pkg::PREAMBLE_BYTE) begin
            state <= rx_pkg::ALIGN_WAIT_IDLE;
          end
        end
        rx_pkg::ALIGN_DATA: begin
          if (dv_r) begin
            fb_valid   <= 1'b1;
            fb_start   <= first_pend;
            first_pend <= 1'b0;
          end else begin
            fb_end     <= ~first_pend;           // only close a started frame
            first_pend <= 1'b0;
            state      <= rx_pkg::ALIGN_IDLE;
          end
        end
        rx_pkg::ALIGN_WAIT_IDLE: begin
          if (dv_fall) state <= rx_pkg::ALIGN_IDLE;
        end
        default: state <= rx_pkg::ALIGN_IDLE;
      endcase
    end
  end

endmodule

// File: hdl/rx_pkg.sv
package rx_pkg;

  // =====================================================================
  // vector types
  // =====================================================================
  typedef logic [7:0]  byte_t;
  typedef logic [10:0] frame_len_t;   // byte count or index within a frame
  typedef logic        slot_t;
  typedef logic [11:0] buf_addr_t;    // {slot, byte index}
  typedef logic [31:0] crc_t;

  localparam int CREDIT_WIDTH = 4;
  typedef logic [CREDIT_WIDTH-1:0] credit_t;

  // =====================================================================
  // frame constants
  // =====================================================================
  localparam byte_t      PREAMBLE_BYTE  = 8'h55;
  localparam byte_t      SFD_BYTE       = 8'hd5;
  localparam crc_t       CRC_RESIDUE    = 32'hc704dd7b;  // good FCS leaves this
  localparam byte_t      TTE_MARK       = 8'h92;
  localparam frame_len_t TTE_MARK_INDEX = 11'd12;        // first type byte
  localparam frame_len_t MIN_FRAME_LEN  = 11'd64;
  localparam frame_len_t MAX_FRAME_LEN  = 11'd1518;
  localparam int         SLOT_BYTES     = 2048;
  localparam int         NUM_SLOTS      = 2;
  localparam int         CREDIT_INIT    = 4;

  // =====================================================================
  // state machines
  // =====================================================================
  typedef enum logic [1:0] {ALIGN_IDLE, ALIGN_HUNT, ALIGN_DATA, ALIGN_WAIT_IDLE} align_state_t;
  typedef enum logic [1:0] {WR_IDLE, WR_WRITE, WR_DROP, WR_POST} writer_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_STREAM, RD_DONE} reader_state_t;

endpackage
